// ==== common/aluPkg.sv ====
`default_nettype none

package aluPkg;

    localparam int XLEN = 32;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4 // Signed compare
    } aluOpT;

endpackage

`default_nettype wire

// ==== common/isaPkg.sv ====
`default_nettype none

package isaPkg;

    // Base opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_OP     = 7'b0110011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_AUIPC  = 7'b0010111
    } opcodeT;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } immSrcT;

    // Writeback source
    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } resultSrcT;

    localparam logic [2:0] F3_ADDSUB = 3'b000; // Also addi
    localparam logic [2:0] F3_AND    = 3'b111;
    localparam logic [2:0] F3_OR     = 3'b110;
    localparam logic [2:0] F3_SLT    = 3'b010;
    localparam logic [2:0] F3_LBU    = 3'b100;
    localparam logic [2:0] F3_SB     = 3'b000;
    localparam logic [2:0] F3_BNE    = 3'b001;

    localparam logic [6:0] F7_ADD = 7'h00;
    localparam logic [6:0] F7_SUB = 7'h20;

endpackage

`default_nettype wire

// ==== decode/mainDecoder.sv ====
`default_nettype none

module mainDecoder (
    input  isaPkg::opcodeT    op,
    input  logic [2:0]        funct3,
    output logic              regWrite,
    output logic              aluSrcA,
    output logic              aluSrcB,
    output logic              memWrite,
    output logic              jump,
    output logic              branch,
    output isaPkg::immSrcT    immSrc,
    output isaPkg::resultSrcT resultSrc
);

    import isaPkg::*;

    always_comb begin
        // Inactive unless the opcode says otherwise
        regWrite  = 1'b0;
        aluSrcA   = 1'b0;
        aluSrcB   = 1'b0;
        memWrite  = 1'b0;
        jump      = 1'b0;
        branch    = 1'b0;
        immSrc    = IMM_I;
        resultSrc = RES_ALU;

        case (op)
            OP_IMM: begin
                if (funct3 == F3_ADDSUB) begin // addi only
                    regWrite = 1'b1;
                    aluSrcB  = 1'b1;
                end
            end
            OP_OP: begin
                if (funct3 inside {F3_ADDSUB, F3_AND, F3_OR, F3_SLT}) begin
                    regWrite = 1'b1;
                end
            end
            OP_LOAD: begin
                if (funct3 == F3_LBU) begin
                    regWrite  = 1'b1;
                    aluSrcB   = 1'b1;
                    resultSrc = RES_MEM;
                end
            end
            OP_STORE: begin
                if (funct3 == F3_SB) begin
                    aluSrcB  = 1'b1;
                    memWrite = 1'b1;
                    immSrc   = IMM_S;
                end
            end
            OP_BRANCH: begin
                if (funct3 == F3_BNE) begin
                    branch = 1'b1; // Registers compared in the ALU
                    immSrc = IMM_B;
                end
            end
            OP_JAL: begin
                regWrite  = 1'b1;
                aluSrcA   = 1'b1;
                aluSrcB   = 1'b1;
                jump      = 1'b1;
                immSrc    = IMM_J;
                resultSrc = RES_PC4;
            end
            OP_JALR: begin
                regWrite  = 1'b1;
                aluSrcB   = 1'b1;
                jump      = 1'b1;
                resultSrc = RES_PC4;
            end
            OP_AUIPC: begin
                regWrite = 1'b1;
                aluSrcA  = 1'b1;
                aluSrcB  = 1'b1;
                immSrc   = IMM_U;
            end
            default: begin
                regWrite = 1'b0; // Unsupported opcodes act as no-ops
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== decode/aluDecoder.sv ====
`default_nettype none

module aluDecoder (
    input  isaPkg::opcodeT op,
    input  logic [2:0]     funct3,
    input  logic [6:0]     funct7,
    output aluPkg::aluOpT  aluOp
);

    import isaPkg::*;
    import aluPkg::*;

    always_comb begin
        aluOp = ALU_ADD; // Addresses, immediates and jump targets

        if (op == OP_BRANCH) begin
            aluOp = ALU_SUB;
        end else if (op == OP_OP) begin
            case (funct3)
                F3_ADDSUB: begin
                    if (funct7 == F7_SUB) begin
                        aluOp = ALU_SUB;
                    end else begin
                        aluOp = ALU_ADD;
                    end
                end
                F3_AND:  aluOp = ALU_AND;
                F3_OR:   aluOp = ALU_OR;
                F3_SLT:  aluOp = ALU_SLT;
                default: aluOp = ALU_ADD; // Not written back anyway
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== decode/controlUnit.sv ====
`default_nettype none

module controlUnit (
    input  logic [aluPkg::XLEN-1:0] instr,
    input  logic                    eq,
    output logic                    regWrite,
    output logic                    aluSrcA,
    output logic                    aluSrcB,
    output logic                    memWrite,
    output logic                    pcSrc,
    output isaPkg::immSrcT          immSrc,
    output isaPkg::resultSrcT       resultSrc,
    output aluPkg::aluOpT           aluOp
);

    import isaPkg::*;

    opcodeT     op;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       jump;
    logic       branch;

    assign op     = opcodeT'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    mainDecoder u_mainDecoder (
        .op        (op),
        .funct3    (funct3),
        .regWrite  (regWrite),
        .aluSrcA   (aluSrcA),
        .aluSrcB   (aluSrcB),
        .memWrite  (memWrite),
        .jump      (jump),
        .branch    (branch),
        .immSrc    (immSrc),
        .resultSrc (resultSrc)
    );

    aluDecoder u_aluDecoder (
        .op     (op),
        .funct3 (funct3),
        .funct7 (funct7),
        .aluOp  (aluOp)
    );

    assign pcSrc = jump | (branch & ~eq); // bne taken when operands differ

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`default_nettype none

module alu (
    input  logic [aluPkg::XLEN-1:0] a,
    input  logic [aluPkg::XLEN-1:0] b,
    input  aluPkg::aluOpT           aluOp,
    output logic [aluPkg::XLEN-1:0] result,
    output logic                    eq
);

    import aluPkg::*;

    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic            lessThan;

    assign sum      = a + b;
    assign diff     = a - b;
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (aluOp)
            ALU_ADD: result = sum;
            ALU_SUB: result = diff;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, lessThan};
            default: result = sum;
        endcase
    end

    // Operand equality does not depend on aluOp
    assign eq = (a == b);

endmodule

`default_nettype wire

// ==== source/regFile.sv ====
`default_nettype none

module regFile (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    input  logic [4:0]              rd,
    input  logic                    we,
    input  logic [aluPkg::XLEN-1:0] wd,
    output logic [aluPkg::XLEN-1:0] rd1,
    output logic [aluPkg::XLEN-1:0] rd2
);

    import aluPkg::*;

    logic [XLEN-1:0] regs [1:31]; // No storage for x0

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != 5'd0)) begin
            regs[rd] <= wd;
        end
    end

    assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== source/immExtend.sv ====
`default_nettype none

module immExtend (
    input  logic [aluPkg::XLEN-1:0] instr,
    input  isaPkg::immSrcT          immSrc,
    output logic [aluPkg::XLEN-1:0] imm
);

    import aluPkg::*;
    import isaPkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (immSrc)
            IMM_I:   imm = {{(XLEN-12){sign}}, instr[31:20]};
            IMM_S:   imm = {{(XLEN-12){sign}}, instr[31:25], instr[11:7]};
            IMM_B:   imm = {{(XLEN-12){sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            IMM_U:   imm = {instr[31:12], 12'b0}; // Upper 20 bits
            IMM_J:   imm = {{(XLEN-20){sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = {{(XLEN-12){sign}}, instr[31:20]};
        endcase
    end

endmodule

`default_nettype wire

// ==== source/rvCore.sv ====
`default_nettype none

module rvCore #(
    parameter int DMEM_BYTES = 256
) (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic [aluPkg::XLEN-1:0] instr,
    output logic [aluPkg::XLEN-1:0] pc,
    output logic                    memWrite,
    output logic [aluPkg::XLEN-1:0] dataAddr,
    output logic [aluPkg::XLEN-1:0] writeData
);

    import aluPkg::*;
    import isaPkg::*;

    localparam int ADDR_BITS = $clog2(DMEM_BYTES);

    logic            regWrite;
    logic            aluSrcA;
    logic            aluSrcB;
    logic            pcSrc;
    logic            eq;
    immSrcT          immSrc;
    resultSrcT       resultSrc;
    aluOpT           aluOp;
    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] srcA;
    logic [XLEN-1:0] srcB;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] pcTarget;
    logic [XLEN-1:0] pcNext;
    logic [7:0]      readByte;
    logic [7:0]      dmem [DMEM_BYTES];

    controlUnit u_controlUnit (
        .instr     (instr),
        .eq        (eq),
        .regWrite  (regWrite),
        .aluSrcA   (aluSrcA),
        .aluSrcB   (aluSrcB),
        .memWrite  (memWrite),
        .pcSrc     (pcSrc),
        .immSrc    (immSrc),
        .resultSrc (resultSrc),
        .aluOp     (aluOp)
    );

    regFile u_regFile (
        .clk   (clk),
        .arstN (arstN),
        .rs1   (instr[19:15]),
        .rs2   (instr[24:20]),
        .rd    (instr[11:7]),
        .we    (regWrite),
        .wd    (result),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    immExtend u_immExtend (
        .instr  (instr),
        .immSrc (immSrc),
        .imm    (imm)
    );

    assign srcA = aluSrcA ? pc : rd1;
    assign srcB = aluSrcB ? imm : rd2;

    alu u_alu (
        .a      (srcA),
        .b      (srcB),
        .aluOp  (aluOp),
        .result (aluResult),
        .eq     (eq)
    );

    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + imm; // Separate adder for the bne target

    // Jumps take the ALU sum with bit 0 cleared and bne takes pcTarget
    always_comb begin
        if (!pcSrc) begin
            pcNext = pcPlus4;
        end else if (aluSrcB) begin
            pcNext = {aluResult[XLEN-1:1], 1'b0};
        end else begin
            pcNext = pcTarget;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    assign dataAddr  = aluResult;
    assign writeData = rd2;
    assign readByte  = dmem[dataAddr[ADDR_BITS-1:0]];

    always_ff @(posedge clk) begin
        if (memWrite) begin
            dmem[dataAddr[ADDR_BITS-1:0]] <= writeData[7:0]; // sb low byte
        end
    end

    always_comb begin
        case (resultSrc)
            RES_ALU: result = aluResult;
            RES_MEM: result = {{(XLEN-8){1'b0}}, readByte}; // lbu zero-extends
            RES_PC4: result = pcPlus4;
            default: result = aluResult;
        endcase
    end

endmodule

`default_nettype wire

// ==== verification/clockGen.sv ====
`default_nettype none

module clockGen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 8
) (
    input  logic rstReq,
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // Reset at time zero and again on every request
    initial begin
        forever begin
            arstN <= 1'b0;
            repeat (RESET_CYCLES) @(posedge clk);
            arstN <= 1'b1; // Released on a rising edge
            @(posedge rstReq);
        end
    end

endmodule

`default_nettype wire

// ==== verification/rvCore_asserts.sv ====
`default_nettype none

module rvCoreAsserts (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic [aluPkg::XLEN-1:0] pc,
    input  logic                    memWrite
);

    pcAligned: assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

    pcInReset: assert property (@(posedge clk) !arstN |-> pc == '0)
        else $error("pc is not zero during reset");

    memWriteKnown: assert property (@(posedge clk) disable iff (!arstN) !$isunknown(memWrite))
        else $error("memWrite is unknown");

endmodule

bind rvCore rvCoreAsserts u_rvCoreAsserts (
    .clk      (clk),
    .arstN    (arstN),
    .pc       (pc),
    .memWrite (memWrite)
);

`default_nettype wire

// ==== verification/rvCoreTb.sv ====
`default_nettype none

module rvCoreTb;

    import aluPkg::*;
    import isaPkg::*;

    localparam int PERIOD          = 100;
    localparam int RESET_CYCLES    = 8;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 100;
    localparam int STEP_LIMIT      = 40;
    localparam int WATCHDOG_TIME   =
        (NUM_TESTS * (CYCLES_PER_TEST + RESET_CYCLES + 2) + RESET_CYCLES) * PERIOD;

    logic            clk;
    logic            arstN;
    logic            rstReq;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pc;
    logic            memWrite;
    logic [XLEN-1:0] dataAddr;
    logic [XLEN-1:0] writeData;
    logic [31:0]     imem [64];
    logic [15:0]     lfsrState;

    clockGen #(.PERIOD(PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clockGen (
        .rstReq (rstReq),
        .clk    (clk),
        .arstN  (arstN)
    );

    rvCore #(.DMEM_BYTES(256)) u_rvCore (
        .clk       (clk),
        .arstN     (arstN),
        .instr     (instr),
        .pc        (pc),
        .memWrite  (memWrite),
        .dataAddr  (dataAddr),
        .writeData (writeData)
    );

    assign instr = imem[pc[7:2]]; // Word index

    function automatic logic lfsrBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 16'hB400;
        end
        return outBit;
    endfunction

    function automatic logic [11:0] randImm12();
        logic [11:0] value;
        for (int i = 0; i < 12; i++) begin
            value[i] = lfsrBit();
        end
        return value;
    endfunction

    function automatic logic [XLEN-1:0] sext12(input logic [11:0] v);
        return {{(XLEN-12){v[11]}}, v};
    endfunction

    // Instruction encoders
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_OP};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input opcodeT op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, F3_SB, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, F3_BNE, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OP_AUIPC};
    endfunction

    task automatic stopRun();
        $display("TESTS FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkWord(input string name, input logic [XLEN-1:0] expVal,
                             input logic [XLEN-1:0] actVal);
        if (actVal !== expVal) begin
            $display("ERR time=%0t %s expected=%h actual=%h", $time, name, expVal, actVal);
            stopRun();
        end
    endtask

    task automatic checkBit(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            $display("ERR time=%0t %s expected=%b actual=%b", $time, name, expVal, actVal);
            stopRun();
        end
    endtask

    // Program is loaded while the core sits in reset
    task automatic loadAndReset(input logic [31:0] prog [$]);
        @(posedge clk);
        rstReq <= 1'b1;
        for (int i = 0; i < 64; i++) begin
            imem[i] <= (i < prog.size()) ? prog[i] : 32'h0;
        end
        @(posedge clk);
        rstReq <= 1'b0;
        @(posedge arstN);
    endtask

    task automatic waitPc(input logic [XLEN-1:0] target);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while ((pc !== target) && (cycles < STEP_LIMIT)) begin
            cycles++;
            @(posedge clk);
        end
        if (pc !== target) begin
            $display("pc never reached %h", target);
            stopRun();
        end
    endtask

    task automatic checkNextPc(input logic [XLEN-1:0] expPc);
        @(posedge clk);
        checkWord("pc", expPc, pc);
    endtask

    task automatic expectStore(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while ((memWrite !== 1'b1) && (cycles < STEP_LIMIT)) begin
            cycles++;
            @(posedge clk);
        end
        if (memWrite !== 1'b1) begin
            $display("No store seen for address %h", addr);
            stopRun();
        end else begin
            checkWord("dataAddr", addr, dataAddr);
            checkWord("writeData", data, writeData);
        end
    endtask

    task automatic testArithmetic();
        logic [11:0]     immA;
        logic [11:0]     immB;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [31:0]     prog [$];
        immA = randImm12();
        immB = randImm12();
        a = sext12(immA);
        b = sext12(immB);
        prog.push_back(encI(immA, 5'd0, F3_ADDSUB, 5'd1, OP_IMM));
        prog.push_back(encI(immB, 5'd0, F3_ADDSUB, 5'd2, OP_IMM));
        prog.push_back(encR(F7_ADD, 5'd2, 5'd1, F3_ADDSUB, 5'd3));
        prog.push_back(encS(12'h010, 5'd3, 5'd0));
        prog.push_back(encR(F7_SUB, 5'd2, 5'd1, F3_ADDSUB, 5'd4));
        prog.push_back(encS(12'h011, 5'd4, 5'd0));
        prog.push_back(encR(F7_ADD, 5'd2, 5'd1, F3_AND, 5'd5));
        prog.push_back(encS(12'h012, 5'd5, 5'd0));
        prog.push_back(encR(F7_ADD, 5'd2, 5'd1, F3_OR, 5'd6));
        prog.push_back(encS(12'h013, 5'd6, 5'd0));
        prog.push_back(encR(F7_ADD, 5'd2, 5'd1, F3_SLT, 5'd7));
        prog.push_back(encS(12'h014, 5'd7, 5'd0));
        loadAndReset(prog);
        expectStore(32'h10, a + b);
        expectStore(32'h11, a - b);
        expectStore(32'h12, a & b);
        expectStore(32'h13, a | b);
        expectStore(32'h14, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    endtask

    task automatic testMemory();
        logic [11:0] value;
        logic [31:0] prog [$];
        value = randImm12();
        prog.push_back(encI(value, 5'd0, F3_ADDSUB, 5'd1, OP_IMM));
        prog.push_back(encS(12'h020, 5'd1, 5'd0));
        prog.push_back(encI(12'h020, 5'd0, F3_LBU, 5'd2, OP_LOAD));
        prog.push_back(encS(12'h021, 5'd2, 5'd0));
        loadAndReset(prog);
        expectStore(32'h20, sext12(value));
        expectStore(32'h21, {24'h0, value[7:0]}); // Upper bits must be clear
    endtask

    task automatic testBranch();
        logic [31:0] prog [$];
        prog.push_back(encI(12'd5, 5'd0, F3_ADDSUB, 5'd1, OP_IMM));
        prog.push_back(encI(12'd7, 5'd0, F3_ADDSUB, 5'd2, OP_IMM));
        prog.push_back(encB(13'd12, 5'd2, 5'd1)); // Taken to 20
        prog.push_back(32'h0);
        prog.push_back(32'h0);
        prog.push_back(encB(13'd8, 5'd1, 5'd1)); // Equal operands fall through
        loadAndReset(prog);
        waitPc(32'd8);
        checkNextPc(32'd8 + 32'd12);
        checkNextPc(32'd20 + 32'd4);
    endtask

    task automatic testJump();
        logic [31:0] prog [$];
        prog.push_back(encI(12'h040, 5'd0, F3_ADDSUB, 5'd1, OP_IMM));
        prog.push_back(encJ(21'd16, 5'd5));
        prog.push_back(32'h0);
        prog.push_back(32'h0);
        prog.push_back(32'h0);
        prog.push_back(32'h0);
        prog.push_back(encS(12'h030, 5'd5, 5'd0)); // Link register out
        prog.push_back(encI(12'h005, 5'd1, 3'b000, 5'd6, OP_JALR));
        loadAndReset(prog);
        waitPc(32'd4);
        checkNextPc(32'd4 + 32'd16);
        expectStore(32'h30, 32'd4 + 32'd4);
        waitPc(32'd28);
        checkNextPc((32'h40 + 32'd5) & ~32'd1);
    endtask

    task automatic testAuipc();
        logic [31:0] prog [$];
        prog.push_back(32'h0);
        prog.push_back(32'h0);
        prog.push_back(encU(20'hABCDE, 5'd1));
        prog.push_back(encS(12'h040, 5'd1, 5'd0));
        loadAndReset(prog);
        expectStore(32'h40, 32'd8 + {20'hABCDE, 12'h000});
    endtask

    task automatic testNoOpAndX0();
        logic [31:0] prog [$];
        prog.push_back(encI(12'h055, 5'd0, F3_ADDSUB, 5'd1, OP_IMM));
        prog.push_back(32'hFFFF_FFFF); // Unknown opcode
        prog.push_back(encI(12'h012, 5'd1, F3_ADDSUB, 5'd0, OP_IMM));
        prog.push_back(encR(F7_ADD, 5'd1, 5'd1, F3_ADDSUB, 5'd0));
        prog.push_back(encS(12'h050, 5'd0, 5'd0));
        loadAndReset(prog);
        waitPc(32'd4);
        checkBit("memWrite", 1'b0, memWrite);
        checkNextPc(32'd8);
        expectStore(32'h50, 32'h0);
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout after %0d time units, the tests did not finish", WATCHDOG_TIME);
        stopRun();
    end

    initial begin
        lfsrState = 16'd85;
        rstReq <= 1'b0;
        for (int i = 0; i < 64; i++) begin
            imem[i] <= 32'h0;
        end
        testArithmetic();
        testMemory();
        testBranch();
        testJump();
        testAuipc();
        testNoOpAndX0();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/aluPkg.sv
common/isaPkg.sv
decode/mainDecoder.sv
decode/aluDecoder.sv
decode/controlUnit.sv
source/alu.sv
source/regFile.sv
source/immExtend.sv
source/rvCore.sv
verification/clockGen.sv
verification/rvCore_asserts.sv
verification/rvCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build rvCoreTb with Verilator, run it, then judge the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module rvCoreTb -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/VrvCoreTb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0
